//--- build.f
logic/memSysPkg.sv
logic/instrCache.sv
logic/dataCache.sv
logic/busArbiter.sv
logic/busMemory.sv
logic/memSystem.sv
sim/memSystemTb.sv

//--- logic/busArbiter.sv
// Two-master bus arbiter
module busArbiter (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             iBusReq,
  input  logic [memSysPkg::WordBits-1:0]   iBusAddr,
  output logic                             iBusReady,
  input  logic                             dBusReq,
  input  logic                             dBusWrite,
  input  logic [memSysPkg::WordBits-1:0]   dBusAddr,
  input  logic [memSysPkg::WordBits-1:0]   dBusWData,
  input  logic [memSysPkg::WordBits/8-1:0] dBusMask,
  output logic                             dBusReady,
  output logic                             memReq,
  output logic                             memWrite,
  output logic [memSysPkg::WordBits-1:0]   memAddr,
  output logic [memSysPkg::WordBits-1:0]   memWData,
  output logic [memSysPkg::WordBits/8-1:0] memMask,
  input  logic                             memReady
);

  memSysPkg::busOwnerT owner;

  // Owner keeps the bus until its request drops, data wins from idle
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      owner <= memSysPkg::OwnerNone;
    else
    begin
      case (owner)
        memSysPkg::OwnerData:
        begin
          if (!dBusReq)
            owner <= iBusReq ? memSysPkg::OwnerInstr : memSysPkg::OwnerNone;
        end
        memSysPkg::OwnerInstr:
        begin
          if (!iBusReq)
            owner <= dBusReq ? memSysPkg::OwnerData : memSysPkg::OwnerNone;
        end
        default:
        begin
          if (dBusReq)
            owner <= memSysPkg::OwnerData;
          else if (iBusReq)
            owner <= memSysPkg::OwnerInstr;
        end
      endcase
    end
  end

  always_comb
  begin
    memReq = 1'b0;
    memWrite = 1'b0;
    memAddr = iBusAddr;
    memWData = '0;
    memMask = '1;
    case (owner)
      memSysPkg::OwnerData:
      begin
        memReq = dBusReq;
        memWrite = dBusWrite;
        memAddr = dBusAddr;
        memWData = dBusWData;
        memMask = dBusMask;
      end
      memSysPkg::OwnerInstr: memReq = iBusReq;
      default: memReq = 1'b0;
    endcase
  end

  assign dBusReady = (owner == memSysPkg::OwnerData) && memReady;
  assign iBusReady = (owner == memSysPkg::OwnerInstr) && memReady;

  assert property (@(posedge clk) disable iff (!rstN)
    !(iBusReady && dBusReady));

  // Memory completes only transfers that some master owns
  assert property (@(posedge clk) disable iff (!rstN)
    memReady |-> owner != memSysPkg::OwnerNone);

endmodule

//--- logic/busMemory.sv
// Wait-state bus memory
module busMemory (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             memReq,
  input  logic                             memWrite,
  input  logic [memSysPkg::WordBits-1:0]   memAddr,
  input  logic [memSysPkg::WordBits-1:0]   memWData,
  input  logic [memSysPkg::WordBits/8-1:0] memMask,
  output logic                             memReady,
  output logic [memSysPkg::WordBits-1:0]   memRData
);

  logic [memSysPkg::WordBits-1:0] mem [memSysPkg::MemWords];
  logic [$clog2(memSysPkg::MemWords)-1:0] wordIdx;
  logic [$clog2(memSysPkg::MemWaitStates+1)-1:0] waitCnt;
  logic finishing;

  initial
  begin
    for (int i = 0; i < memSysPkg::MemWords; i++)
      mem[i] = memSysPkg::MemInitKey ^ memSysPkg::WordBits'(i);
  end

  // Word address, upper bits wrap
  assign wordIdx = memAddr[2 +: $clog2(memSysPkg::MemWords)];
  assign finishing = memReq && !memReady &&
    (waitCnt == $bits(waitCnt)'(memSysPkg::MemWaitStates));

  // Ready is a one-cycle pulse, counter restarts behind it
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      memReady <= 1'b0;
      waitCnt <= '0;
    end
    else if (memReady || !memReq)
    begin
      memReady <= 1'b0;
      waitCnt <= '0;
    end
    else if (finishing)
      memReady <= 1'b1;
    else
      waitCnt <= waitCnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (finishing)
      memRData <= mem[wordIdx];
    if (memReq && memReady && memWrite)
    begin
      for (int b = 0; b < memSysPkg::WordBits/8; b++)
      begin
        if (memMask[b])
          mem[wordIdx][8*b +: 8] <= memWData[8*b +: 8];
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    memReq && !memReady |=> $stable(memAddr));

endmodule

//--- logic/dataCache.sv
// Direct-mapped write-through data cache
module dataCache (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             cacheEn,
  input  logic                             invalidate,
  input  logic                             dataValid,
  input  logic                             dataWrite,
  input  logic [memSysPkg::WordBits-1:0]   dataAddr,
  input  logic [memSysPkg::WordBits-1:0]   dataWData,
  input  logic [memSysPkg::WordBits/8-1:0] dataByteMask,
  output logic                             dataReady,
  output logic                             dataDone,
  output logic [memSysPkg::WordBits-1:0]   dataRData,
  output logic                             busReq,
  output logic                             busWrite,
  output logic [memSysPkg::WordBits-1:0]   busAddr,
  output logic [memSysPkg::WordBits-1:0]   busWData,
  output logic [memSysPkg::WordBits/8-1:0] busMask,
  input  logic                             busReady,
  input  logic [memSysPkg::WordBits-1:0]   busRData
);

  memSysPkg::cacheStateT state;
  logic [memSysPkg::WordBits-1:0] reqAddr;
  logic [memSysPkg::WordBits-1:0] reqWData;
  logic [memSysPkg::WordBits/8-1:0] reqMask;
  logic reqWrite;
  logic [memSysPkg::TagBits-1:0] reqTag;
  logic [memSysPkg::IndexBits-1:0] reqIndex;
  logic [memSysPkg::OffsetBits-1:0] reqOffset;
  logic [memSysPkg::OffsetBits-1:0] fillCnt;
  logic bypass;
  logic hit;
  logic lastWord;
  logic [memSysPkg::NumLines-1:0] validBits;
  logic [memSysPkg::TagBits-1:0] tagArr [memSysPkg::NumLines];
  logic [memSysPkg::WordBits-1:0] dataArr [memSysPkg::NumLines][memSysPkg::LineWords];

  // Replace only the byte lanes selected by mask
  function automatic logic [memSysPkg::WordBits-1:0] mergeBytes(
    input logic [memSysPkg::WordBits-1:0] oldWord,
    input logic [memSysPkg::WordBits-1:0] newWord,
    input logic [memSysPkg::WordBits/8-1:0] mask
  );
    logic [memSysPkg::WordBits-1:0] result;
    result = oldWord;
    for (int b = 0; b < memSysPkg::WordBits/8; b++)
    begin
      if (mask[b])
        result[8*b +: 8] = newWord[8*b +: 8];
    end
    return result;
  endfunction

  assign reqOffset = reqAddr[2 +: memSysPkg::OffsetBits];
  assign reqIndex = reqAddr[2 + memSysPkg::OffsetBits +: memSysPkg::IndexBits];
  assign reqTag = reqAddr[memSysPkg::WordBits-1 -: memSysPkg::TagBits];

  assign hit = validBits[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign lastWord = bypass || (&fillCnt);

  assign dataReady = (state == memSysPkg::Idle);
  assign busReq = (state == memSysPkg::Fill) || (state == memSysPkg::Write);
  assign busWrite = (state == memSysPkg::Write);
  // Stores reuse fillCnt as the word offset
  assign busAddr = {reqTag, reqIndex, fillCnt, 2'b00};
  assign busWData = reqWData;
  assign busMask = busWrite ? reqMask : '1;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= memSysPkg::Idle;
      dataDone <= 1'b0;
      validBits <= '0;
      fillCnt <= '0;
      bypass <= 1'b0;
    end
    else
    begin
      dataDone <= 1'b0;
      case (state)
        memSysPkg::Idle:
        begin
          if (invalidate)
            validBits <= '0;
          if (dataValid)
            state <= memSysPkg::Lookup;
        end
        memSysPkg::Lookup:
        begin
          if (reqWrite)
          begin
            fillCnt <= reqOffset;
            state <= memSysPkg::Write;
          end
          else if (cacheEn && hit)
          begin
            dataDone <= 1'b1;
            state <= memSysPkg::Idle;
          end
          else
          begin
            bypass <= !cacheEn;
            fillCnt <= cacheEn ? '0 : reqOffset;
            state <= memSysPkg::Fill;
          end
        end
        memSysPkg::Fill:
        begin
          if (busReady)
          begin
            fillCnt <= fillCnt + 1'b1;
            if (lastWord)
            begin
              dataDone <= 1'b1;
              state <= memSysPkg::Idle;
              if (!bypass)
                validBits[reqIndex] <= 1'b1;
            end
          end
        end
        memSysPkg::Write:
        begin
          if (busReady)
          begin
            dataDone <= 1'b1;
            state <= memSysPkg::Idle;
          end
        end
        default: state <= memSysPkg::Idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (dataValid && dataReady)
    begin
      reqAddr <= dataAddr;
      reqWData <= dataWData;
      reqMask <= dataByteMask;
      reqWrite <= dataWrite;
    end
    // Present lines track stores even while the cache is off
    if (state == memSysPkg::Lookup && reqWrite && hit)
      dataArr[reqIndex][reqOffset] <= mergeBytes(dataArr[reqIndex][reqOffset], reqWData, reqMask);
    if (state == memSysPkg::Lookup && !reqWrite)
      dataRData <= dataArr[reqIndex][reqOffset];
    if (state == memSysPkg::Fill && busReady)
    begin
      if (!bypass)
        dataArr[reqIndex][fillCnt] <= busRData;
      if (fillCnt == reqOffset)
        dataRData <= busRData;
      if (lastWord && !bypass)
        tagArr[reqIndex] <= reqTag;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    dataValid && dataReady && dataWrite |-> dataByteMask != '0);

endmodule

//--- logic/instrCache.sv
// Direct-mapped instruction cache
module instrCache (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           cacheEn,
  input  logic                           invalidate,
  input  logic                           fetchValid,
  input  logic [memSysPkg::WordBits-1:0] fetchAddr,
  output logic                           fetchReady,
  output logic                           fetchDone,
  output logic [memSysPkg::WordBits-1:0] fetchData,
  output logic                           busReq,
  output logic [memSysPkg::WordBits-1:0] busAddr,
  input  logic                           busReady,
  input  logic [memSysPkg::WordBits-1:0] busRData
);

  memSysPkg::cacheStateT state;
  logic [memSysPkg::WordBits-1:0] reqAddr;
  logic [memSysPkg::TagBits-1:0] reqTag;
  logic [memSysPkg::IndexBits-1:0] reqIndex;
  logic [memSysPkg::OffsetBits-1:0] reqOffset;
  logic [memSysPkg::OffsetBits-1:0] fillCnt;
  logic bypass;
  logic hit;
  logic lastWord;
  logic [memSysPkg::NumLines-1:0] validBits;
  logic [memSysPkg::TagBits-1:0] tagArr [memSysPkg::NumLines];
  logic [memSysPkg::WordBits-1:0] dataArr [memSysPkg::NumLines][memSysPkg::LineWords];

  // Address fields of the held request, byte bits dropped
  assign reqOffset = reqAddr[2 +: memSysPkg::OffsetBits];
  assign reqIndex = reqAddr[2 + memSysPkg::OffsetBits +: memSysPkg::IndexBits];
  assign reqTag = reqAddr[memSysPkg::WordBits-1 -: memSysPkg::TagBits];

  assign hit = validBits[reqIndex] && (tagArr[reqIndex] == reqTag);
  // Uncached read is one word, a fill ends at the last offset
  assign lastWord = bypass || (&fillCnt);

  assign fetchReady = (state == memSysPkg::Idle);
  assign busReq = (state == memSysPkg::Fill);
  assign busAddr = {reqTag, reqIndex, fillCnt, 2'b00};

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= memSysPkg::Idle;
      fetchDone <= 1'b0;
      validBits <= '0;
      fillCnt <= '0;
      bypass <= 1'b0;
    end
    else
    begin
      fetchDone <= 1'b0;
      case (state)
        memSysPkg::Idle:
        begin
          if (invalidate)
            validBits <= '0;
          if (fetchValid)
            state <= memSysPkg::Lookup;
        end
        memSysPkg::Lookup:
        begin
          if (cacheEn && hit)
          begin
            fetchDone <= 1'b1;
            state <= memSysPkg::Idle;
          end
          else
          begin
            // Disabled cache reads only the requested word
            bypass <= !cacheEn;
            fillCnt <= cacheEn ? '0 : reqOffset;
            state <= memSysPkg::Fill;
          end
        end
        memSysPkg::Fill:
        begin
          if (busReady)
          begin
            fillCnt <= fillCnt + 1'b1;
            if (lastWord)
            begin
              fetchDone <= 1'b1;
              state <= memSysPkg::Idle;
              if (!bypass)
                validBits[reqIndex] <= 1'b1;
            end
          end
        end
        default: state <= memSysPkg::Idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetchValid && fetchReady)
      reqAddr <= fetchAddr;
    if (state == memSysPkg::Lookup)
      fetchData <= dataArr[reqIndex][reqOffset];
    if (state == memSysPkg::Fill && busReady)
    begin
      if (!bypass)
        dataArr[reqIndex][fillCnt] <= busRData;
      if (fillCnt == reqOffset)
        fetchData <= busRData;
      if (lastWord && !bypass)
        tagArr[reqIndex] <= reqTag;
    end
  end

  // A started transfer is held until the bus completes it
  assert property (@(posedge clk) disable iff (!rstN)
    busReq && !busReady |=> busReq);

endmodule

//--- logic/memSysPkg.sv
// Memory system shared definitions
package memSysPkg;

  // Data and address width
  localparam int WordBits = 32;

  // Cache geometry
  localparam int LineWords = 4;
  localparam int NumLines = 64;

  // Byte address split: tag | index | word offset | byte
  localparam int OffsetBits = 2;
  localparam int IndexBits = 6;
  localparam int TagBits = 22;

  // Memory array size in words, addresses wrap
  localparam int MemWords = 4096;

  // Cycles with memReady low before a transfer completes
  localparam int MemWaitStates = 2;

  // Word i of memory starts out as MemInitKey ^ i
  localparam logic [WordBits-1:0] MemInitKey = 32'hA5A5_0000;

  // Cache controller states
  typedef enum logic [1:0] {
    Idle,
    Lookup,
    Fill,
    Write
  } cacheStateT;

  // Current bus owner
  typedef enum logic [1:0] {
    OwnerNone,
    OwnerData,
    OwnerInstr
  } busOwnerT;

endpackage

//--- logic/memSystem.sv
// Cache and bus memory system
module memSystem (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             iCacheEn,
  input  logic                             dCacheEn,
  input  logic                             iInvalidate,
  input  logic                             dInvalidate,
  input  logic                             fetchValid,
  input  logic [memSysPkg::WordBits-1:0]   fetchAddr,
  output logic                             fetchReady,
  output logic                             fetchDone,
  output logic [memSysPkg::WordBits-1:0]   fetchData,
  input  logic                             dataValid,
  input  logic                             dataWrite,
  input  logic [memSysPkg::WordBits-1:0]   dataAddr,
  input  logic [memSysPkg::WordBits-1:0]   dataWData,
  input  logic [memSysPkg::WordBits/8-1:0] dataByteMask,
  output logic                             dataReady,
  output logic                             dataDone,
  output logic [memSysPkg::WordBits-1:0]   dataRData
);

  // Instruction master
  logic                           iBusReq;
  logic                           iBusReady;
  logic [memSysPkg::WordBits-1:0] iBusAddr;

  // Data master
  logic                             dBusReq;
  logic                             dBusWrite;
  logic                             dBusReady;
  logic [memSysPkg::WordBits-1:0]   dBusAddr;
  logic [memSysPkg::WordBits-1:0]   dBusWData;
  logic [memSysPkg::WordBits/8-1:0] dBusMask;

  // Slave side, read data goes to both caches
  logic                             memReq;
  logic                             memWrite;
  logic                             memReady;
  logic [memSysPkg::WordBits-1:0]   memAddr;
  logic [memSysPkg::WordBits-1:0]   memWData;
  logic [memSysPkg::WordBits/8-1:0] memMask;
  logic [memSysPkg::WordBits-1:0]   memRData;

  instrCache instrCache_inst (
    .clk       (clk        ),
    .rstN      (rstN       ),
    .cacheEn   (iCacheEn   ),
    .invalidate(iInvalidate),
    .fetchValid(fetchValid ),
    .fetchAddr (fetchAddr  ),
    .fetchReady(fetchReady ),
    .fetchDone (fetchDone  ),
    .fetchData (fetchData  ),
    .busReq    (iBusReq    ),
    .busAddr   (iBusAddr   ),
    .busReady  (iBusReady  ),
    .busRData  (memRData   )
  );

  dataCache dataCache_inst (
    .clk         (clk         ),
    .rstN        (rstN        ),
    .cacheEn     (dCacheEn    ),
    .invalidate  (dInvalidate ),
    .dataValid   (dataValid   ),
    .dataWrite   (dataWrite   ),
    .dataAddr    (dataAddr    ),
    .dataWData   (dataWData   ),
    .dataByteMask(dataByteMask),
    .dataReady   (dataReady   ),
    .dataDone    (dataDone    ),
    .dataRData   (dataRData   ),
    .busReq      (dBusReq     ),
    .busWrite    (dBusWrite   ),
    .busAddr     (dBusAddr    ),
    .busWData    (dBusWData   ),
    .busMask     (dBusMask    ),
    .busReady    (dBusReady   ),
    .busRData    (memRData    )
  );

  busArbiter busArbiter_inst (
    .clk      (clk      ),
    .rstN     (rstN     ),
    .iBusReq  (iBusReq  ),
    .iBusAddr (iBusAddr ),
    .iBusReady(iBusReady),
    .dBusReq  (dBusReq  ),
    .dBusWrite(dBusWrite),
    .dBusAddr (dBusAddr ),
    .dBusWData(dBusWData),
    .dBusMask (dBusMask ),
    .dBusReady(dBusReady),
    .memReq   (memReq   ),
    .memWrite (memWrite ),
    .memAddr  (memAddr  ),
    .memWData (memWData ),
    .memMask  (memMask  ),
    .memReady (memReady )
  );

  busMemory busMemory_inst (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .memReq  (memReq  ),
    .memWrite(memWrite),
    .memAddr (memAddr ),
    .memWData(memWData),
    .memMask (memMask ),
    .memReady(memReady),
    .memRData(memRData)
  );

endmodule

//--- sim/memSystemTb.sv
// Memory system testbench
module memSystemTb;

  localparam int ColdFetches = 16;
  localparam int HitLines = 6;
  localparam int MixedOps = 64;
  localparam int ParallelOps = 32;
  localparam int ToggleOps = 48;
  // Test 2 does five fetches per line and tests 4 and 5 use both ports
  localparam int TotalReqs = ColdFetches + HitLines * 5 + MixedOps + 2 * ParallelOps
    + 2 * ToggleOps;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic clk = 1'b0;
  logic rstN;
  logic iCacheEn;
  logic dCacheEn;
  logic iInvalidate;
  logic dInvalidate;
  logic fetchValid;
  logic [31:0] fetchAddr;
  logic fetchReady;
  logic fetchDone;
  logic [31:0] fetchData;
  logic dataValid;
  logic dataWrite;
  logic [31:0] dataAddr;
  logic [31:0] dataWData;
  logic [3:0] dataByteMask;
  logic dataReady;
  logic dataDone;
  logic [31:0] dataRData;

  logic [31:0] lfsr = 32'h659d074b;
  logic [31:0] model [4096];
  int cycle = 0;
  int checkCount = 0;
  int errCount = 0;

  // Pre-built requests for the concurrent test
  logic [31:0] parFetchAddr [ParallelOps];
  logic parWrite [ParallelOps];
  logic [31:0] parAddr [ParallelOps];
  logic [31:0] parWData [ParallelOps];
  logic [3:0] parMask [ParallelOps];

  memSystem memSystem_inst (
    .clk         (clk         ),
    .rstN        (rstN        ),
    .iCacheEn    (iCacheEn    ),
    .dCacheEn    (dCacheEn    ),
    .iInvalidate (iInvalidate ),
    .dInvalidate (dInvalidate ),
    .fetchValid  (fetchValid  ),
    .fetchAddr   (fetchAddr   ),
    .fetchReady  (fetchReady  ),
    .fetchDone   (fetchDone   ),
    .fetchData   (fetchData   ),
    .dataValid   (dataValid   ),
    .dataWrite   (dataWrite   ),
    .dataAddr    (dataAddr    ),
    .dataWData   (dataWData   ),
    .dataByteMask(dataByteMask),
    .dataReady   (dataReady   ),
    .dataDone    (dataDone    ),
    .dataRData   (dataRData   )
  );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] nextRandom(input int n);
    logic [31:0] result;
    logic outBit;
    result = '0;
    for (int i = 0; i < n; i++)
    begin
      outBit = lfsr[0];
      lfsr = lfsr >> 1;
      if (outBit)
        lfsr = lfsr ^ LfsrTaps;
      result = {result[30:0], outBit};
    end
    return result;
  endfunction

  // Fetches stay in the lower half of memory with random byte bits
  function automatic logic [31:0] randomFetchAddr(input int windowBits);
    logic [31:0] idx;
    logic [31:0] low;
    idx = nextRandom(windowBits);
    low = nextRandom(2);
    return {18'd0, 1'b0, idx[10:0], low[1:0]};
  endfunction

  // Data traffic stays in the upper half so fetched words never go stale
  function automatic logic [31:0] randomDataAddr(input int windowBits);
    logic [31:0] idx;
    idx = nextRandom(windowBits);
    return {18'd0, 1'b1, idx[10:0], 2'b00};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual)
    begin
      errCount++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic reportTest(input int num, input string title, input int errsBefore);
    if (errCount == errsBefore)
      $display("Test %0d %s: ok", num, title);
    else
      $display("Test %0d %s: %0d errors", num, title, errCount - errsBefore);
  endtask

  // Called just after a rising edge and returns at the edge that sees fetchDone
  task automatic doFetch(input logic [31:0] addr, output logic [31:0] data,
                         output int latency);
    int startCycle;
    fetchValid <= 1'b1;
    fetchAddr <= addr;
    @(posedge clk);
    while (!(fetchValid && fetchReady))
      @(posedge clk);
    startCycle = cycle;
    fetchValid <= 1'b0;
    @(posedge clk);
    while (!fetchDone)
      @(posedge clk);
    latency = cycle - startCycle;
    data = fetchData;
  endtask

  task automatic runFetch(input logic [31:0] addr, input logic expectHit);
    logic [31:0] data;
    int latency;
    doFetch(addr, data, latency);
    checkValue("fetchData", model[addr[13:2]], data);
    if (expectHit)
      checkValue("fetch hit latency", 32'd2, latency);
  endtask

  task automatic genDataOp(input int windowBits, output logic write, output logic [31:0] addr,
                           output logic [31:0] wdata, output logic [3:0] mask);
    logic [31:0] bits;
    bits = nextRandom(1);
    write = bits[0];
    addr = randomDataAddr(windowBits);
    wdata = nextRandom(32);
    bits = nextRandom(4);
    mask = (bits[3:0] == 4'b0) ? 4'b0001 : bits[3:0];
  endtask

  task automatic runDataOp(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] mask);
    logic [31:0] laneMask;
    dataValid <= 1'b1;
    dataWrite <= write;
    dataAddr <= addr;
    dataWData <= wdata;
    dataByteMask <= mask;
    @(posedge clk);
    while (!(dataValid && dataReady))
      @(posedge clk);
    dataValid <= 1'b0;
    @(posedge clk);
    while (!dataDone)
      @(posedge clk);
    if (write)
    begin
      laneMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
      model[addr[13:2]] = (model[addr[13:2]] & ~laneMask) | (wdata & laneMask);
    end
    else
      checkValue("dataRData", model[addr[13:2]], dataRData);
  endtask

  // Watchdog sized from the request count
  initial
  begin
    repeat (TotalReqs * 40 + 1000) @(posedge clk);
    $display("Watchdog timeout, requests did not complete in time");
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    logic w;
    logic [31:0] a;
    logic [31:0] wd;
    logic [3:0] m;
    logic [31:0] lineBase;
    logic [31:0] low;
    int errsBefore;

    for (int i = 0; i < 4096; i++)
      model[i] = memSysPkg::MemInitKey ^ 32'(i);
    rstN = 1'b0;
    iCacheEn = 1'b1;
    dCacheEn = 1'b1;
    iInvalidate = 1'b0;
    dInvalidate = 1'b0;
    fetchValid = 1'b0;
    fetchAddr = '0;
    dataValid = 1'b0;
    dataWrite = 1'b0;
    dataAddr = '0;
    dataWData = '0;
    dataByteMask = '0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    errsBefore = errCount;
    for (int i = 0; i < ColdFetches; i++)
      runFetch(randomFetchAddr(11), 1'b0);
    reportTest(1, "cold fetches", errsBefore);

    errsBefore = errCount;
    for (int i = 0; i < HitLines; i++)
    begin
      lineBase = randomFetchAddr(11) & ~32'hF;
      runFetch(lineBase, 1'b0);
      for (int k = 0; k < 4; k++)
      begin
        low = nextRandom(2);
        runFetch(lineBase | (32'(k) << 2) | low, 1'b1);
      end
    end
    reportTest(2, "fetch hits", errsBefore);

    // Small window so stores land on cached lines
    errsBefore = errCount;
    for (int i = 0; i < MixedOps; i++)
    begin
      genDataOp(6, w, a, wd, m);
      runDataOp(w, a, wd, m);
    end
    reportTest(3, "mixed loads and stores", errsBefore);

    errsBefore = errCount;
    for (int i = 0; i < ParallelOps; i++)
    begin
      parFetchAddr[i] = randomFetchAddr(8);
      genDataOp(8, parWrite[i], parAddr[i], parWData[i], parMask[i]);
    end
    fork
      for (int i = 0; i < ParallelOps; i++)
        runFetch(parFetchAddr[i], 1'b0);
      for (int j = 0; j < ParallelOps; j++)
        runDataOp(parWrite[j], parAddr[j], parWData[j], parMask[j]);
    join
    reportTest(4, "concurrent ports", errsBefore);

    // Invalidate while both caches idle, then run the middle third disabled
    errsBefore = errCount;
    iInvalidate <= 1'b1;
    dInvalidate <= 1'b1;
    @(posedge clk);
    iInvalidate <= 1'b0;
    dInvalidate <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < ToggleOps; i++)
    begin
      if (i == ToggleOps / 3)
      begin
        iCacheEn <= 1'b0;
        dCacheEn <= 1'b0;
      end
      if (i == 2 * ToggleOps / 3)
      begin
        iCacheEn <= 1'b1;
        dCacheEn <= 1'b1;
      end
      genDataOp(6, w, a, wd, m);
      // Loads only at first so the disabled stores meet present lines
      if (i < ToggleOps / 3)
        w = 1'b0;
      runDataOp(w, a, wd, m);
      runFetch(randomFetchAddr(6), 1'b0);
    end
    reportTest(5, "invalidate and enable toggle", errsBefore);

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
